//--- verification/ghost_sd_golden.txt
# P records hold data seed, CRC flip flag (1 inverts one bit) and test name
# K records hold pad block number and GOST counter input, in RAM write order
P 0000b978 0 good_0
P 0000b979 1 bad_crc
P 0000b97a 0 good_1
K 0 123456789abcdef0
K 0 123456789abcdef1
K 0 123456789abcdef2
K 0 123456789abcdef3
K 0 123456789abcdef4
K 0 123456789abcdef5
K 0 123456789abcdef6
K 0 123456789abcdef7
K 0 123456789abcdef8
K 0 123456789abcdef9
K 0 123456789abcdefa
K 0 123456789abcdefb
K 0 123456789abcdefc
K 0 123456789abcdefd
K 0 123456789abcdefe
K 0 123456789abcdeff
K 0 123456789abcdf00
K 0 123456789abcdf01
K 0 123456789abcdf02
K 0 123456789abcdf03
K 0 123456789abcdf04
K 0 123456789abcdf05
K 0 123456789abcdf06
K 0 123456789abcdf07
K 0 123456789abcdf08
K 0 123456789abcdf09
K 0 123456789abcdf0a
K 0 123456789abcdf0b
K 0 123456789abcdf0c
K 0 123456789abcdf0d
K 0 123456789abcdf0e
K 0 123456789abcdf0f
K 0 123456789abcdf10
K 0 123456789abcdf11
K 0 123456789abcdf12
K 0 123456789abcdf13
K 0 123456789abcdf14
K 0 123456789abcdf15
K 0 123456789abcdf16
K 0 123456789abcdf17
K 0 123456789abcdf18
K 0 123456789abcdf19
K 0 123456789abcdf1a
K 0 123456789abcdf1b
K 0 123456789abcdf1c
K 0 123456789abcdf1d
K 0 123456789abcdf1e
K 0 123456789abcdf1f
K 0 123456789abcdf20
K 0 123456789abcdf21
K 0 123456789abcdf22
K 0 123456789abcdf23
K 0 123456789abcdf24
K 0 123456789abcdf25
K 0 123456789abcdf26
K 0 123456789abcdf27
K 0 123456789abcdf28
K 0 123456789abcdf29
K 0 123456789abcdf2a
K 0 123456789abcdf2b
K 0 123456789abcdf2c
K 0 123456789abcdf2d
K 0 123456789abcdf2e
K 0 123456789abcdf2f
K 1 123456789abcdf30
K 1 123456789abcdf31

//--- src.f
+incdir+design
design/ghost_pkg.sv
design/gost_core.sv
design/otp_gen.sv
design/ram_4k_block.sv
design/sd_crc16.sv
design/sd_block_engine.sv
design/ghost_sd.sv
verification/ghost_sd_tb.sv

//--- Makefile
SOURCES := $(shell grep -v '^+' src.f) design/ghost_settings.svh

all: run

obj_dir/Vghost_sd_tb: src.f $(SOURCES)
	verilator --binary --timing -Wno-fatal --top-module ghost_sd_tb -Mdir obj_dir -f src.f

run: obj_dir/Vghost_sd_tb verification/ghost_sd_golden.txt
	./obj_dir/Vghost_sd_tb | tee sim.log
	grep -q "^ALL CHECKS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- verification/ghost_sd_tb.sv
`timescale 1ns/1ps
`include "ghost_settings.svh"

module ghost_sd_tb
  import ghost_pkg::*;
();

  localparam int NIBS = `SD_BLOCK_NIBBLES;

  // RFC 4357 test S-boxes K1..K8, entry 0 in the top nibble
  localparam logic [63:0] SBOX [8] = '{
    64'h4A92D80E6B1C7F53,
    64'hEB4C6DFA23810759,
    64'h581DA342EFC7609B,
    64'h7DA1089FE46CB253,
    64'h6C715FD84A9E03B2,
    64'h4BA0721D36859CFE,
    64'hDB413F590AE7682C,
    64'h1FD057A4923E6B8C
  };

  logic    iclk = 1'b0;
  logic    arst_n;
  logic    start;
  nibble_t data_in;
  nibble_t data_oe;
  logic    clk_sd;
  logic    success;
  logic    fail;

  int          p_seed [$];  // Golden P records
  bit          p_flip [$];
  string       p_name [$];
  int          k_blk  [$];  // Golden K records
  gost_block_t k_ctr  [$];
  bit          loaded = 1'b0;

  nibble_t sent_nib [NIBS];
  nibble_t resp_nib [NIBS];
  crc16_t  tx_crc   [4];
  int      seed     = 47480;
  int      checks   = 0;
  int      errors   = 0;
  int      oe_errs  = 0;
  int      succ_cnt = 0;
  int      fail_cnt = 0;
  int      good_idx = 0;
  bit      oe_quiet = 1'b0; // D[3:0] must stay released

  ghost_sd i_dut (
    .iclk   (iclk),
    .arst_n (arst_n),
    .start  (start),
    .data_in(data_in),
    .data_oe(data_oe),
    .clk_sd (clk_sd),
    .success(success),
    .fail   (fail)
  );

  always #5 iclk = ~iclk;

  // Pulse counters and bus monitor
  always @(posedge iclk) begin
    if (success) succ_cnt <= succ_cnt + 1;
    if (fail) fail_cnt <= fail_cnt + 1;
    if (oe_quiet && (data_oe != 4'h0)) begin
      if (oe_errs == 0) $display("DUT pulls a data line low after a block with a bad CRC");
      oe_errs <= oe_errs + 1;
    end
  end

  // ================================================
  // Compare tasks
  // ================================================

  task automatic check_nibble(input string tname, input string what, input nibble_t exp,
                              input nibble_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s %s expected %h actual %h", tname, what, exp, act);
    end
  endtask

  task automatic check_crc(input string tname, input string what, input crc16_t exp,
                           input crc16_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s %s expected %h actual %h", tname, what, exp, act);
    end
  endtask

  task automatic check_flag(input string tname, input string what, input bit exp,
                            input bit act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s %s expected %b actual %b", tname, what, exp, act);
    end
  endtask

  // ================================================
  // Reference models
  // ================================================

  // CRC16 0x1021 over one line of a block, MSB first
  task automatic line_crc(input int line, input bit use_resp, output crc16_t crc);
    nibble_t v;
    bit      fb;
    crc = '0;
    for (int i = 0; i < NIBS; i++) begin
      v   = use_resp ? resp_nib[i] : sent_nib[i];
      fb  = v[line] ^ crc[15];
      crc = {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
    end
  endtask

  function automatic gost_block_t gost_encrypt(input gost_block_t blk);
    gost_key_t   key_v;
    logic [31:0] a;     // Half entering the round function
    logic [31:0] b;
    logic [31:0] s;
    logic [31:0] t;
    int          idx;
    key_v = `GHOST_KEY;
    a     = blk[31:0];
    b     = blk[63:32];
    for (int rnd = 0; rnd < 32; rnd++) begin
      idx = (rnd < 24) ? rnd % 8 : 7 - rnd % 8;
      s   = a + key_v[32 * idx +: 32];
      for (int j = 0; j < 8; j++) begin
        t[4 * j +: 4] = SBOX[j][4 * (15 - s[4 * j +: 4]) +: 4];
      end
      t = b ^ {t[20:0], t[31:21]};
      b = a;
      a = t;
    end
    return {a, b};
  endfunction

  // ================================================
  // Golden file and card model
  // ================================================

  task automatic load_golden();
    int            fd;
    int            n;
    logic [7:0]    tag;
    logic [1023:0] rest;
    logic [31:0]   seed_v;
    logic [3:0]    flip_v;
    logic [127:0]  name_v;
    logic [7:0]    blk_v;
    gost_block_t   ctr_v;
    fd = $fopen("verification/ghost_sd_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden file verification/ghost_sd_golden.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", tag);
      if (n != 1) break;
      if (tag == "#") begin
        n = $fgets(rest, fd);
      end else if (tag == "P") begin
        name_v = '0;
        n = $fscanf(fd, "%h %h %s", seed_v, flip_v, name_v);
        p_seed.push_back(int'(seed_v));
        p_flip.push_back(flip_v != 4'h0);
        p_name.push_back($sformatf("%0s", name_v));
      end else if (tag == "K") begin
        n = $fscanf(fd, "%h %h", blk_v, ctr_v);
        k_blk.push_back(int'(blk_v));
        k_ctr.push_back(ctr_v);
      end else begin
        $display("Unknown record type in the golden file");
        errors++;
      end
    end
    $fclose(fd);
  endtask

  // Card changes D[3:0] after the falling card clock
  task automatic drive_nibble(input nibble_t v);
    @(negedge clk_sd);
    @(posedge iclk);
    data_in <= v;
  endtask

  task automatic send_block();
    nibble_t v;
    drive_nibble(4'h0);
    for (int i = 0; i < NIBS; i++) begin
      drive_nibble(sent_nib[i]);
    end
    for (int b = 0; b < 16; b++) begin
      for (int l = 0; l < 4; l++) begin
        v[l] = tx_crc[l][15 - b];
      end
      drive_nibble(v);
    end
    drive_nibble(4'hf); // End bit
  endtask

  task automatic capture_response(input string tname);
    nibble_t line;
    crc16_t  got [4];
    crc16_t  exp;
    line = 4'hf;
    while (line == 4'hf) begin
      @(posedge clk_sd);
      line = ~data_oe; // Pulled high unless driven
    end
    check_nibble(tname, "start nibble", 4'h0, line);
    for (int i = 0; i < NIBS; i++) begin
      @(posedge clk_sd);
      resp_nib[i] = ~data_oe;
    end
    for (int b = 0; b < 16; b++) begin
      @(posedge clk_sd);
      line = ~data_oe;
      for (int l = 0; l < 4; l++) begin
        got[l] = {got[l][14:0], line[l]};
      end
    end
    @(posedge clk_sd);
    check_nibble(tname, "end nibble", 4'hf, ~data_oe);
    for (int l = 0; l < 4; l++) begin
      line_crc(l, 1'b1, exp);
      check_crc(tname, $sformatf("crc line %0d", l), exp, got[l]);
    end
  endtask

  // ================================================
  // Test sequence
  // ================================================

  task automatic run_block(input int t);
    string       tname;
    bit          good;
    int          s0;
    int          f0;
    gost_block_t word;
    gost_block_t ks [$];
    tname = p_name[t];
    good  = !p_flip[t];
    seed  = p_seed[t];
    for (int i = 0; i < NIBS; i++) begin
      sent_nib[i] = nibble_t'($random(seed));
    end
    for (int l = 0; l < 4; l++) begin
      line_crc(l, 1'b0, tx_crc[l]);
    end
    if (!good) tx_crc[2][5] = ~tx_crc[2][5]; // One wrong CRC bit on D2
    for (int k = 0; k < k_blk.size(); k++) begin
      if (k_blk[k] == good_idx) ks.push_back(gost_encrypt(k_ctr[k]));
    end
    oe_quiet = !good;
    s0       = succ_cnt;
    f0       = fail_cnt;
    @(posedge iclk);
    start <= 1'b1;
    @(posedge iclk);
    start <= 1'b0;
    fork
      send_block();
      if (good) capture_response(tname);
    join
    while ((succ_cnt == s0) && (fail_cnt == f0)) @(posedge iclk);
    repeat (8) @(posedge iclk);
    check_flag(tname, "success pulse", good, succ_cnt != s0);
    check_flag(tname, "fail pulse", !good, fail_cnt != f0);
    if ((succ_cnt - s0 > 1) || (fail_cnt - f0 > 1)) begin
      $display("%s result pulse lasted more than one cycle", tname);
      errors++;
    end
    if (good) begin
      for (int i = 0; i < 16 * ks.size(); i++) begin
        word = ks[i / 16];
        check_nibble(tname, $sformatf("nibble %0d", i),
                     sent_nib[i] ^ word[4 * (15 - i % 16) +: 4], resp_nib[i]);
      end
      good_idx++;
    end
  endtask

  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = 3 * p_seed.size() * (1100 * 2 * `SD_CLK_DIV + 3200);
    repeat (limit) @(posedge iclk);
    $display("Timeout, the tests did not finish within %0d clock cycles", limit);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    arst_n  = 1'b0;
    start   = 1'b0;
    data_in = 4'hf;
    load_golden();
    loaded = 1'b1;
    repeat (2) @(posedge iclk);
    arst_n <= 1'b1;
    repeat (3) @(posedge iclk);
    check_flag("reset", "success", 1'b0, success);
    check_flag("reset", "fail", 1'b0, fail);
    check_flag("reset", "clk_sd", 1'b1, clk_sd);
    check_nibble("reset", "data_oe", 4'h0, data_oe);
    for (int t = 0; t < p_seed.size(); t++) begin
      run_block(t);
    end
    oe_quiet = 1'b0;
    repeat (4) @(posedge iclk);
    $display("Checks: %0d, errors: %0d", checks, errors + oe_errs);
    if (errors + oe_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- design/ghost_sd.sv
`timescale 1ns/1ps
`include "ghost_settings.svh"

module ghost_sd
  import ghost_pkg::*;
(
  input  logic    iclk,
  input  logic    arst_n,
  input  logic    start,
  input  nibble_t data_in,  // D[3:0] as seen on the pads
  output nibble_t data_oe,  // Pull low enables for D[3:0]
  output logic    clk_sd,
  output logic    success,
  output logic    fail
);

  logic    gen_otp;
  logic    new_otp;
  logic    otp_ready;
  logic    write_en_raw;
  logic    write_en_otp;
  nibble_t wdata_raw;
  nibble_t wdata_otp;
  addr_t   addr;      // Shared read address
  addr_t   addr_otp;
  nibble_t block_raw;
  nibble_t block_otp;
  nibble_t res_block;

  sd_block_engine sd_inst (
    .iclk        (iclk),
    .arst_n      (arst_n),
    .start       (start),
    .data_in     (data_in),
    .data_oe     (data_oe),
    .clk_sd      (clk_sd),
    .gen_otp     (gen_otp),
    .new_otp     (new_otp),
    .otp_ready   (otp_ready),
    .addr        (addr),
    .wdata_raw   (wdata_raw),
    .write_en_raw(write_en_raw),
    .rdata       (res_block),
    .success     (success),
    .fail        (fail)
  );

  otp_gen otp_gen_inst (
    .iclk    (iclk),
    .arst_n  (arst_n),
    .start   (gen_otp),
    .new_otp (new_otp),
    .key     (`GHOST_KEY),
    .iv      (`GHOST_IV),
    .addr    (addr_otp),
    .wdata   (wdata_otp),
    .write_en(write_en_otp),
    .done    (otp_ready)
  );

  ram_4k_block otp_block (
    .iclk    (iclk),
    .waddr   (addr_otp),
    .raddr   (addr),
    .din     (wdata_otp),
    .write_en(write_en_otp),
    .dout    (block_otp)
  );

  ram_4k_block raw_block (
    .iclk    (iclk),
    .waddr   (addr),
    .raddr   (addr),
    .din     (wdata_raw),
    .write_en(write_en_raw),
    .dout    (block_raw)
  );

  // Encrypted nibble
  assign res_block = block_raw ^ block_otp;

endmodule

//--- design/sd_block_engine.sv
`timescale 1ns/1ps
`include "ghost_settings.svh"

module sd_block_engine
  import ghost_pkg::*;
(
  input  logic    iclk,
  input  logic    arst_n,
  input  logic    start,
  input  nibble_t data_in,
  output nibble_t data_oe,
  output logic    clk_sd,
  output logic    gen_otp,
  output logic    new_otp,
  input  logic    otp_ready,
  output addr_t   addr,
  output nibble_t wdata_raw,
  output logic    write_en_raw,
  input  nibble_t rdata,
  output logic    success,
  output logic    fail
);

  localparam int    DIV_W    = $clog2(`SD_CLK_DIV + 1);
  localparam addr_t LAST_NIB = addr_t'(`SD_BLOCK_NIBBLES - 1);

  sd_state_t        state;
  logic [DIV_W-1:0] div_cnt;
  logic             tick;
  logic             rise;
  logic             fall;
  addr_t            nib_cnt;
  logic [3:0]       bit_cnt;
  logic             crc_err;
  logic             crc_clear;
  logic             crc_shift;
  nibble_t          crc_din;
  nibble_t          crc_bit;   // Current CRC bit of each line
  crc16_t           crc_val [4];

  // ================================================
  // Card clock edges
  // ================================================

  assign tick = (div_cnt == DIV_W'(`SD_CLK_DIV - 1));
  assign rise = tick && !clk_sd && (state != st_idle); // Sample point
  assign fall = tick &&  clk_sd && (state != st_idle); // Drive point

  // ================================================
  // Per line CRC16
  // ================================================

  assign crc_clear = ((state == st_idle) && start) || ((state == st_end_bit) && rise);
  assign crc_shift = ((state == st_receive) && rise) ||
                     (((state == st_send_start) || (state == st_send)) && fall);
  assign crc_din   = (state == st_receive) ? data_in : rdata;

  for (genvar i = 0; i < 4; i++) begin : g_line
    sd_crc16 crc_inst (
      .iclk  (iclk),
      .arst_n(arst_n),
      .clear (crc_clear),
      .shift (crc_shift),
      .bit_in(crc_din[i]),
      .crc   (crc_val[i])
    );
    assign crc_bit[i] = crc_val[i][~bit_cnt]; // MSB first
  end

  // ================================================
  // Control FSM
  // ================================================

  always_ff @(posedge iclk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= st_idle;
      div_cnt      <= '0;
      clk_sd       <= 1'b1;
      nib_cnt      <= '0;
      bit_cnt      <= '0;
      crc_err      <= 1'b0;
      data_oe      <= '0;
      addr         <= '0;
      write_en_raw <= 1'b0;
      gen_otp      <= 1'b0;
      new_otp      <= 1'b0;
      success      <= 1'b0;
      fail         <= 1'b0;
    end else begin
      gen_otp      <= 1'b0;
      new_otp      <= 1'b0;
      success      <= 1'b0;
      fail         <= 1'b0;
      write_en_raw <= 1'b0;

      // Card clock rests high when idle
      if (state == st_idle) begin
        div_cnt <= '0;
        clk_sd  <= 1'b1;
      end else if (tick) begin
        div_cnt <= '0;
        clk_sd  <= ~clk_sd;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end

      case (state)
        st_idle: if (start) begin
          gen_otp <= 1'b1; // Pad is built while the block arrives
          crc_err <= 1'b0;
          state   <= st_wait_start;
        end
        st_wait_start: if (rise && (data_in == 4'h0)) begin
          nib_cnt <= '0;
          state   <= st_receive;
        end
        st_receive: if (rise) begin
          addr         <= nib_cnt;
          write_en_raw <= 1'b1;
          nib_cnt      <= nib_cnt + 1'b1;
          if (nib_cnt == LAST_NIB) begin
            bit_cnt <= '0;
            state   <= st_receive_crc;
          end
        end
        st_receive_crc: if (rise) begin
          if (data_in != crc_bit) crc_err <= 1'b1;
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 4'hf) state <= st_end_bit;
        end
        st_end_bit: if (rise) begin
          addr <= '0; // Prefetch first response nibble
          if (crc_err || (data_in != 4'hf)) begin
            crc_err <= 1'b1;
            state   <= st_report;
          end else begin
            state <= st_wait_otp;
          end
        end
        st_wait_otp: if (fall && otp_ready) begin
          data_oe <= 4'hf; // Start bit, all lines low
          nib_cnt <= '0;
          state   <= st_send_start;
        end
        st_send_start, st_send: if (fall) begin
          data_oe <= ~rdata; // Open drain, a zero pulls low
          addr    <= nib_cnt + 1'b1;
          nib_cnt <= nib_cnt + 1'b1;
          if (nib_cnt == LAST_NIB) begin
            bit_cnt <= '0;
            state   <= st_send_crc;
          end else begin
            state <= st_send;
          end
        end
        st_send_crc: if (fall) begin
          data_oe <= ~crc_bit;
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 4'hf) state <= st_send_end;
        end
        st_send_end: if (fall) begin
          data_oe <= '0; // End bit by release
          state   <= st_report;
        end
        st_report: if (rise) begin
          success <= !crc_err;
          new_otp <= !crc_err;
          fail    <= crc_err;
          state   <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Raw nibble goes out with its write strobe
  always_ff @(posedge iclk) begin
    if ((state == st_receive) && rise) wdata_raw <= data_in;
  end

endmodule

//--- design/sd_crc16.sv
`timescale 1ns/1ps

module sd_crc16
  import ghost_pkg::*;
(
  input  logic   iclk,
  input  logic   arst_n,
  input  logic   clear,
  input  logic   shift,
  input  logic   bit_in,
  output crc16_t crc
);

  localparam crc16_t POLY = 16'h1021; // x^16 + x^12 + x^5 + 1

  logic feedback;

  assign feedback = bit_in ^ crc[15];

  always_ff @(posedge iclk or negedge arst_n) begin
    if (!arst_n) begin
      crc <= '0;
    end else if (clear) begin
      crc <= '0;
    end else if (shift) begin
      crc <= {crc[14:0], 1'b0} ^ (feedback ? POLY : 16'h0000);
    end
  end

endmodule

//--- design/ram_4k_block.sv
`timescale 1ns/1ps

module ram_4k_block (
  input  logic       iclk,
  input  logic [9:0] waddr,
  input  logic [9:0] raddr,
  input  logic [3:0] din,
  input  logic       write_en,
  output logic [3:0] dout
);

  logic [3:0] mem [1024];

  always_ff @(posedge iclk) begin
    if (write_en) begin
      mem[waddr] <= din;
    end
    dout <= mem[raddr]; // Old data on a same address collision
  end

endmodule

//--- design/otp_gen.sv
`timescale 1ns/1ps
`include "ghost_settings.svh"

module otp_gen
  import ghost_pkg::*;
(
  input  logic        iclk,
  input  logic        arst_n,
  input  logic        start,
  input  logic        new_otp,
  input  gost_key_t   key,
  input  gost_block_t iv,
  output addr_t       addr,
  output nibble_t     wdata,
  output logic        write_en,
  output logic        done
);

  localparam int BLK_W    = $clog2(`SD_BLOCK_NIBBLES / 16);
  localparam int LAST_BLK = `SD_BLOCK_NIBBLES / 16 - 1;

  gost_block_t      ctr;       // Running counter
  gost_block_t      base;      // Counter value at start of current pad
  gost_block_t      ks;        // Keystream word being written out
  gost_block_t      core_din;
  gost_block_t      core_dout;
  logic             core_start;
  logic             core_done;
  logic             wr_active;
  logic [3:0]       nib_cnt;
  logic [BLK_W-1:0] blk_cnt;
  logic             last_blk;

  assign last_blk = (blk_cnt == BLK_W'(LAST_BLK));

  // Next block is started during the last write of the previous one
  assign core_start = start | (wr_active & (nib_cnt == 4'hf) & ~last_blk);
  assign core_din   = start ? base : ctr;

  gost_core gost_inst (
    .iclk  (iclk),
    .arst_n(arst_n),
    .start (core_start),
    .key   (key),
    .din   (core_din),
    .dout  (core_dout),
    .done  (core_done)
  );

  always_ff @(posedge iclk or negedge arst_n) begin
    if (!arst_n) begin
      ctr       <= iv;
      base      <= iv;
      wr_active <= 1'b0;
      nib_cnt   <= '0;
      blk_cnt   <= '0;
      done      <= 1'b0;
    end else begin
      if (new_otp) base <= ctr; // Commit pad as used

      if (start) begin
        ctr       <= base; // Unused pad is regenerated
        wr_active <= 1'b0;
        nib_cnt   <= '0;
        blk_cnt   <= '0;
        done      <= 1'b0;
      end else begin
        if (core_done) begin
          ctr       <= ctr + 1'b1;
          wr_active <= 1'b1;
        end
        if (wr_active) begin
          nib_cnt <= nib_cnt + 1'b1;
          if (nib_cnt == 4'hf) begin
            wr_active <= 1'b0;
            if (last_blk) done <= 1'b1;
            else          blk_cnt <= blk_cnt + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (core_done) ks <= core_dout;
  end

  assign addr     = {blk_cnt, nib_cnt};
  assign wdata    = ks[{~nib_cnt, 2'b00} +: 4]; // MS nibble first
  assign write_en = wr_active;

endmodule

//--- design/gost_core.sv
`timescale 1ns/1ps

module gost_core
  import ghost_pkg::*;
(
  input  logic        iclk,
  input  logic        arst_n,
  input  logic        start,
  input  gost_key_t   key,
  input  gost_block_t din,
  output gost_block_t dout,
  output logic        done
);

  // S-box rows K1..K8 of the test parameter set, entry 0 in the top nibble
  localparam logic [63:0] SBOX [8] = '{
    64'h4A92D80E6B1C7F53,
    64'hEB4C6DFA23810759,
    64'h581DA342EFC7609B,
    64'h7DA1089FE46CB253,
    64'h6C715FD84A9E03B2,
    64'h4BA0721D36859CFE,
    64'hDB413F590AE7682C,
    64'h1FD057A4923E6B8C
  };

  logic [31:0] n1;      // Low half, goes through the round function
  logic [31:0] n2;
  logic [4:0]  round;
  logic        busy;
  logic [2:0]  key_sel;
  logic [31:0] subkey;
  logic [31:0] sum;
  logic [31:0] subst;
  logic [31:0] f_out;

  function automatic logic [3:0] sbox_lookup(input logic [2:0] row, input logic [3:0] x);
    return SBOX[row][{~x, 2'b00} +: 4];
  endfunction

  // ================================================
  // Round function
  // ================================================

  // K0..K7 for rounds 0..23, then K7..K0
  assign key_sel = (round < 5'd24) ? round[2:0] : ~round[2:0];
  assign subkey  = key[32*key_sel +: 32];
  assign sum     = n1 + subkey; // mod 2^32

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      subst[4*i +: 4] = sbox_lookup(3'(i), sum[4*i +: 4]);
    end
  end

  assign f_out = {subst[20:0], subst[31:21]}; // Rotate left by 11

  // ================================================
  // Round sequencing
  // ================================================

  always_ff @(posedge iclk or negedge arst_n) begin
    if (!arst_n) begin
      busy  <= 1'b0;
      round <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy  <= 1'b1;
        round <= '0;
      end else if (busy) begin
        round <= round + 1'b1;
        if (round == 5'd31) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // Feistel halves
  always_ff @(posedge iclk) begin
    if (start) begin
      n2 <= din[63:32];
      n1 <= din[31:0];
    end else if (busy) begin
      n1 <= n2 ^ f_out;
      n2 <= n1;
    end
  end

  // Last round has no swap, so undo it here
  assign dout = {n1, n2};

endmodule

//--- design/ghost_pkg.sv
package ghost_pkg;

  typedef logic [3:0]   nibble_t;     // One beat on D[3:0]
  typedef logic [9:0]   addr_t;       // RAM address
  typedef logic [63:0]  gost_block_t;
  typedef logic [255:0] gost_key_t;
  typedef logic [15:0]  crc16_t;

  // Card side engine states
  typedef enum logic [3:0] {
    st_idle,
    st_wait_start,
    st_receive,
    st_receive_crc,
    st_end_bit,
    st_wait_otp,
    st_send_start,
    st_send,
    st_send_crc,
    st_send_end,
    st_report
  } sd_state_t;

endpackage

//--- design/ghost_settings.svh
`ifndef GHOST_SETTINGS_SVH
`define GHOST_SETTINGS_SVH

// Cipher key, word i of the key is subkey Ki
`define GHOST_KEY 256'h733d2c20_65686573_74746769_79676120_626e7373_20657369_326c6568_33206d54

// Counter start value for the first pad block
`define GHOST_IV 64'h1234_5678_9abc_def0

// iclk cycles per card clock half period
`define SD_CLK_DIV 2

// One 512 byte block on four lines
`define SD_BLOCK_NIBBLES 1024

`endif
